// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -Wall -Wno-fatal
TOP      := lsu_tb
FILELIST := lsu_mem.f

SRCS := $(shell grep -v '^+' $(FILELIST)) verif/lsu_tb_util.svh
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// ==== lsu_mem.f ====
+incdir+verif
verilog/lsu_pkg.sv
verilog/lsu_port.sv
verilog/dmem_arbiter.sv
verilog/data_sram.sv
verilog/lsu_top.sv
verif/lsu_tb.sv

// ==== verif/lsu_tb_util.svh ====
`ifndef LSU_TB_UTIL_SVH
`define LSU_TB_UTIL_SVH

// galois form, feedback mask for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
        nxt = nxt ^ 32'h8020_0003;
    end
    return nxt;
endfunction

// value a load returns from the word it reads
function automatic logic [31:0] extract_load(input logic [31:0] word, input lsu_op_t op,
                                             input logic [1:0] off);
    logic [7:0]  lane_b;
    logic [15:0] lane_h;
    logic [31:0] val;
    lane_b = word[int'(off)*8 +: 8];
    lane_h = off[1] ? word[31:16] : word[15:0];   // halfword ignores bit 0
    case (op)
        LDB:     val = {{24{lane_b[7]}}, lane_b};
        LDBU:    val = {24'h0, lane_b};
        LDH:     val = {{16{lane_h[15]}}, lane_h};
        LDHU:    val = {16'h0, lane_h};
        LDW:     val = word;
        default: val = 32'h0;                     // stores complete with zero
    endcase
    return val;
endfunction

// memory word after a store lands on it
function automatic logic [31:0] merge_store(input logic [31:0] old, input lsu_op_t op,
                                            input logic [1:0] off, input logic [31:0] data);
    logic [31:0] merged;
    merged = old;
    case (op)
        STB:     merged[int'(off)*8 +: 8] = data[7:0];
        STH:     merged[(off[1] ? 16 : 0) +: 16] = data[15:0];
        STW:     merged = data;
        default: ;
    endcase
    return merged;
endfunction

`endif

// ==== verif/lsu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_tb
    import lsu_pkg::*;
();

    localparam int MAX_CYCLES = 4000;
    localparam int ROUNDS     = 20;
    localparam int RAND_OPS   = 250;                // per port
    localparam logic [31:0] EXT_VALS [2] = '{32'h80ff_80ff, 32'h7f01_7f01};

    logic                 clk;
    logic                 rstn;
    logic [NUM_PORTS-1:0] issue;
    lsu_cmd_t             cmd [NUM_PORTS];
    logic [NUM_PORTS-1:0] busy;
    logic [NUM_PORTS-1:0] result_valid;
    logic [XLEN-1:0]      result [NUM_PORTS];

    logic [XLEN-1:0] model [MEM_WORDS] = '{default: '0};   // shadow of data_sram
    logic [XLEN-1:0] exp_res [NUM_PORTS];
    int              done_cycle [NUM_PORTS];
    int              cycles = 0;
    int              first_port;
    logic [31:0]     lfsr = 32'h9b1e;
    logic            solo;                          // port 0 runs alone with fixed latency
    logic [1:0]      rst_q = '0;                    // reset seen one or two edges back
    logic            take0;

    `include "lsu_tb_util.svh"

    lsu_top DUT (
        .clk          (clk),
        .rstn         (rstn),
        .issue        (issue),
        .cmd          (cmd),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    assign take0 = issue[0] && !busy[0];

    always @(posedge clk) begin
        rst_q  <= {rst_q[0], !rstn};
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            protocol_error("timeout, operations did not finish within the cycle limit");
        end
    end

    task automatic stop_on_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
        $display("FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
        stop_on_failure();
    endtask

    task automatic protocol_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        stop_on_failure();
    endtask

    assert property (@(posedge clk) (|rst_q) |-> busy == '0 && result_valid == '0)
        else protocol_error("busy or result_valid high in or just after reset");

    assert property (@(posedge clk) disable iff (!rstn)
        solo |-> result_valid[0] == $past(take0, 3))
        else protocol_error("port 0 result_valid not exactly two edges after issue");

    assert property (@(posedge clk) disable iff (!rstn)
        solo && ($past(take0, 1) || $past(take0, 2)) |-> busy[0])
        else protocol_error("port 0 busy low while its operation is in flight");

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_chk
        assert property (@(posedge clk) disable iff (!rstn)
            result_valid[p] |-> result[p] == exp_res[p])
            else value_mismatch($sformatf("result[%0d]", p), exp_res[p], result[p]);
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    task automatic run_op(input int p, input lsu_op_t op, input logic [31:0] base,
                          input logic [31:0] imm, input logic [31:0] data);
        logic [31:0] addr;
        int          word;
        addr = base + imm;
        word = int'(addr[WORD_ADDR_W+1:2]);
        do begin
            @(negedge clk);
        end while (busy[p]);
        if (op inside {STB, STH, STW}) begin
            model[word] = merge_store(model[word], op, addr[1:0], data);
            exp_res[p]  = '0;
        end else begin
            exp_res[p] = extract_load(model[word], op, addr[1:0]);
        end
        cmd[p]   = '{base: base, imm: imm, data: data, op: op};
        issue[p] = 1'b1;
        @(negedge clk);
        issue[p] = 1'b0;
        while (!result_valid[p]) begin
            @(negedge clk);
        end
        done_cycle[p] = cycles;
        @(posedge clk);                             // result is checked on this edge
    endtask

    // each port keeps to its own 16 words
    task automatic random_op(input int p);
        lsu_op_t     op;
        int          word;
        logic [31:0] target;
        logic [31:0] base;
        op     = lsu_op_t'(rand_bits(3));
        word   = p * 128 + int'(rand_bits(4));
        target = 32'(word * 4) + rand_bits(2);
        base   = rand_bits(32);
        run_op(p, op, base, target - base, rand_bits(32));
    endtask

    initial begin
        rstn  = 1'b0;
        issue = '0;
        solo  = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            cmd[p]     = '0;
            exp_res[p] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        solo = 1'b1;
        run_op(0, STW, 32'h0000_0100, 32'h0000_0020, 32'hdead_beef);
        run_op(0, LDW, 32'h0000_012c, 32'hffff_fff4, 32'h0);
        for (int off = 0; off < 4; off++) begin
            run_op(0, STW, 32'h40, 32'h0, 32'h1122_3344);
            run_op(0, STB, 32'h40, 32'(off), 32'h5566_77a0 + 32'(off));
            run_op(0, LDW, 32'h40, 32'h0, 32'h0);
            run_op(0, STW, 32'h40, 32'h0, 32'h1122_3344);
            run_op(0, STH, 32'h40, 32'(off), 32'h9abc_c0de);
            run_op(0, LDW, 32'h40, 32'h0, 32'h0);
        end
        for (int v = 0; v < 2; v++) begin
            run_op(0, STW, 32'h80, 32'h0, EXT_VALS[v]);
            for (int off = 0; off < 4; off++) begin
                run_op(0, LDB, 32'h80, 32'(off), 32'h0);
                run_op(0, LDBU, 32'h80, 32'(off), 32'h0);
                run_op(0, LDH, 32'h80, 32'(off), 32'h0);
                run_op(0, LDHU, 32'h80, 32'(off), 32'h0);
            end
        end
        solo = 1'b0;
        for (int r = 0; r < ROUNDS; r++) begin
            fork
                random_op(0);
                random_op(1);
            join
            first_port = (done_cycle[1] < done_cycle[0]) ? 1 : 0;
            assert (first_port == r % 2)
                else value_mismatch("first_done_port", 32'(r % 2), 32'(first_port));
        end
        fork
            repeat (RAND_OPS) random_op(0);
            repeat (RAND_OPS) random_op(1);
        join
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/data_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_sram
    import lsu_pkg::*;
(
    input  logic            clk,
    input  logic            rstn,
    input  mem_req_t        req,
    output logic            data_valid,
    output logic [XLEN-1:0] rdata
);

    logic [XLEN-1:0] mem [MEM_WORDS] = '{default: '0};

    // byte lane writes, read returns the word as it was before the edge
    always_ff @(posedge clk) begin
        if (req.valid && req.write) begin
            for (int b = 0; b < BE_W; b++) begin
                if (req.be[b]) begin
                    mem[req.waddr][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
        if (req.valid) begin
            rdata <= mem[req.waddr];
        end
    end

    // one return per accepted request, loads and stores alike
    always_ff @(posedge clk) begin
        if (!rstn) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= req.valid;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dmem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmem_arbiter
    import lsu_pkg::*;
(
    input  logic            clk,
    input  logic            rstn,
    input  mem_req_t        port_req [NUM_PORTS],
    input  logic            sram_data_valid,
    input  logic [XLEN-1:0] sram_rdata,
    output mem_rsp_t        port_rsp [NUM_PORTS],
    output mem_req_t        sram_req
);

    logic [PORT_IDX_W-1:0] rr_ptr;                  // port with top priority
    logic [PORT_IDX_W-1:0] cand;
    logic [PORT_IDX_W-1:0] gnt_idx;
    logic [PORT_IDX_W-1:0] gnt_q;                   // owner of the next return
    logic                  gnt_any;
    logic                  contend;

    // first valid request at or after the pointer wins
    always_comb begin
        gnt_any = 1'b0;
        gnt_idx = rr_ptr;
        contend = 1'b0;
        cand    = '0;
        for (int k = 0; k < NUM_PORTS; k++) begin
            cand = PORT_IDX_W'((int'(rr_ptr) + k) % NUM_PORTS);
            if (port_req[cand].valid) begin
                if (gnt_any) begin
                    contend = 1'b1;                 // someone else is waiting
                end else begin
                    gnt_any = 1'b1;
                    gnt_idx = cand;
                end
            end
        end
    end

    always_comb begin
        sram_req       = port_req[gnt_idx];
        sram_req.valid = gnt_any;
    end

    // priority rotates only when a request lost, so simultaneous
    // rounds alternate between the ports
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rr_ptr <= '0;
            gnt_q  <= '0;
        end else if (gnt_any) begin
            gnt_q <= gnt_idx;
            if (contend) begin
                rr_ptr <= PORT_IDX_W'((int'(gnt_idx) + 1) % NUM_PORTS);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            port_rsp[i].accept     = gnt_any && (gnt_idx == PORT_IDX_W'(i));
            port_rsp[i].data_valid = sram_data_valid && (gnt_q == PORT_IDX_W'(i));
            port_rsp[i].rdata      = sram_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    localparam int NUM_PORTS   = 2;
    localparam int PORT_IDX_W  = 1;                 // clog2 of NUM_PORTS
    localparam int XLEN        = 32;
    localparam int BE_W        = XLEN / 8;          // one enable per byte lane
    localparam int MEM_WORDS   = 256;
    localparam int WORD_ADDR_W = 8;

    // memory stage operations, loads first then stores
    typedef enum logic [2:0] {
        LDB  = 3'd0,
        LDH  = 3'd1,
        LDW  = 3'd2,
        LDBU = 3'd3,
        LDHU = 3'd4,
        STB  = 3'd5,
        STH  = 3'd6,
        STW  = 3'd7
    } lsu_op_t;

    // command from the execute stage
    typedef struct packed {
        logic [XLEN-1:0] base;                      // base register value
        logic [XLEN-1:0] imm;                       // address offset
        logic [XLEN-1:0] data;                      // store source, unused by loads
        lsu_op_t         op;
    } lsu_cmd_t;

    // port to memory
    typedef struct packed {
        logic                   valid;              // held until accept
        logic                   write;              // 1 store, 0 load
        logic [WORD_ADDR_W-1:0] waddr;              // word address
        logic [BE_W-1:0]        be;
        logic [XLEN-1:0]        wdata;              // already lane aligned
    } mem_req_t;

    // memory to port
    typedef struct packed {
        logic            accept;                    // request taken this cycle
        logic            data_valid;                // read data back or write done
        logic [XLEN-1:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/lsu_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_port
    import lsu_pkg::*;
(
    input  logic            clk,
    input  logic            rstn,
    input  logic            issue,
    input  lsu_cmd_t        cmd,
    input  mem_rsp_t        rsp,
    output mem_req_t        req,
    output logic            busy,
    output logic            result_valid,
    output logic [XLEN-1:0] result
);

    logic [XLEN-1:0] addr;
    logic [1:0]      off;
    logic            take;
    logic            is_store;
    logic [BE_W-1:0] be_nxt;
    logic [XLEN-1:0] wdata_nxt;

    lsu_op_t         op_q;                          // op of the operation in flight
    logic [1:0]      off_q;                         // byte offset in flight
    logic [7:0]      ld_byte;
    logic [15:0]     ld_half;
    logic [XLEN-1:0] ld_val;

    assign addr     = cmd.base + cmd.imm;
    assign off      = addr[1:0];
    assign take     = issue && !busy;               // issue while busy is dropped
    assign is_store = cmd.op inside {STB, STH, STW};

    // byte enables and lane alignment of the store data
    always_comb begin
        be_nxt    = '0;
        wdata_nxt = cmd.data;
        case (cmd.op)
            STB: begin
                be_nxt    = BE_W'(4'b0001 << off);
                wdata_nxt = cmd.data << {off, 3'b000};
            end
            STH: begin
                be_nxt    = off[1] ? 4'b1100 : 4'b0011;   // bit 0 ignored
                wdata_nxt = cmd.data << {off[1], 4'b0000};
            end
            STW: begin
                be_nxt = 4'b1111;
            end
            default: ;                              // loads leave be clear
        endcase
    end

    // request level, raised after issue and dropped after accept
    always_ff @(posedge clk) begin
        if (!rstn) begin
            req.valid <= 1'b0;
        end else begin
            if (take) begin
                req.valid <= 1'b1;
                req.write <= is_store;
                req.waddr <= addr[WORD_ADDR_W+1:2];
                req.be    <= be_nxt;
                req.wdata <= wdata_nxt;
                op_q      <= cmd.op;
                off_q     <= off;
            end else if (rsp.accept) begin
                req.valid <= 1'b0;
            end
        end
    end

    // pick the addressed lane out of the returned word
    assign ld_byte = 8'(rsp.rdata >> {off_q, 3'b000});
    assign ld_half = 16'(rsp.rdata >> {off_q[1], 4'b0000});

    always_comb begin
        case (op_q)
            LDB:     ld_val = {{24{ld_byte[7]}}, ld_byte};
            LDH:     ld_val = {{16{ld_half[15]}}, ld_half};
            LDW:     ld_val = rsp.rdata;
            LDBU:    ld_val = {24'b0, ld_byte};
            LDHU:    ld_val = {16'b0, ld_half};
            default: ld_val = '0;                   // stores report zero
        endcase
    end

    // busy spans issue to completion, result_valid marks the end
    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy         <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= busy && rsp.data_valid;
            if (take) begin
                busy <= 1'b1;
            end else if (rsp.data_valid) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp.data_valid) begin
            result <= ld_val;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top
    import lsu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rstn,
    input  logic [NUM_PORTS-1:0] issue,
    input  lsu_cmd_t             cmd [NUM_PORTS],
    output logic [NUM_PORTS-1:0] busy,
    output logic [NUM_PORTS-1:0] result_valid,
    output logic [XLEN-1:0]      result [NUM_PORTS]
);

    mem_req_t        port_req [NUM_PORTS];
    mem_rsp_t        port_rsp [NUM_PORTS];
    mem_req_t        sram_req;
    logic            sram_data_valid;
    logic [XLEN-1:0] sram_rdata;

    generate
        for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
            lsu_port u_port (
                .clk          (clk),
                .rstn         (rstn),
                .issue        (issue[p]),
                .cmd          (cmd[p]),
                .rsp          (port_rsp[p]),
                .req          (port_req[p]),
                .busy         (busy[p]),
                .result_valid (result_valid[p]),
                .result       (result[p])
            );
        end
    endgenerate

    dmem_arbiter u_arb (
        .clk             (clk),
        .rstn            (rstn),
        .port_req        (port_req),
        .sram_data_valid (sram_data_valid),
        .sram_rdata      (sram_rdata),
        .port_rsp        (port_rsp),
        .sram_req        (sram_req)
    );

    data_sram u_sram (
        .clk        (clk),
        .rstn       (rstn),
        .req        (sram_req),
        .data_valid (sram_data_valid),
        .rdata      (sram_rdata)
    );

endmodule

`default_nettype wire
